// ==== hw/datapath_config.svh ====
// word width, register count and reset pc macros for the scalar datapath
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// data and address width
`define DP_WORD_W 32

// architectural registers, r0 reads as zero
`define DP_NREGS 16

// first fetch address after reset
`define DP_RESET_PC 32'h0000_0000

`endif

// ==== hw/datapath_pkg.sv ====
// datapath package: word and register types, opcode enum, instruction layout, latch payloads
`include "datapath_config.svh"

package datapath_pkg;

    typedef logic [`DP_WORD_W-1:0] word_t;
    typedef logic [$clog2(`DP_NREGS)-1:0] reg_sel_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LW   = 4'h6,
        OP_SW   = 4'h7,
        OP_BEQ  = 4'h8,
        OP_BNE  = 4'h9,
        OP_JAL  = 4'hA,
        OP_HALT = 4'hB
    } opcode_t;

    // instruction word, msb first: op rd rs1 rs2 imm
    typedef struct packed {
        opcode_t     op;
        reg_sel_t    rd;
        reg_sel_t    rs1;
        reg_sel_t    rs2;
        logic [15:0] imm;
    } instr_t;

    // fetch to scoreboard
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
    } fetch_t;

    // scoreboard to execute, operands already read
    typedef struct packed {
        logic        valid;
        opcode_t     op;
        reg_sel_t    rd;
        word_t       rdat1;
        word_t       rdat2;
        logic [15:0] imm;
        word_t       pc;
    } issue_t;

    // execute to writeback
    typedef struct packed {
        logic     done;
        logic     reg_en;
        reg_sel_t reg_sel;
        word_t    wdat;
    } execute_t;

endpackage

// ==== hw/pipe_latch.sv ====
// pipe_latch: pipeline register for any payload type, with flush and hold
`timescale 1ns/1ps

module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush wins over hold so a squashed entry never survives a stall
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
// fetch_stage: pc register, instruction memory request, one-entry hold buffer, redirect
`timescale 1ns/1ps
`include "datapath_config.svh"

module fetch_stage (
    input  logic                  CLK,
    input  logic                  nrst,
    input  logic                  ihit,
    input  datapath_pkg::word_t   imemload,
    input  logic                  freeze,
    input  logic                  misprediction,
    input  datapath_pkg::word_t   correct_pc,
    output logic                  imemREN,
    output datapath_pkg::word_t   imemaddr,
    output datapath_pkg::fetch_t  fetch_out
);
    import datapath_pkg::*;

    word_t  pc;
    word_t  redirect_pc;
    word_t  buf_instr;
    word_t  buf_pc;
    logic   pending;
    logic   discard;
    logic   stopped;
    logic   buf_valid;
    logic   got;
    logic   take;
    logic   open_next;
    instr_t f_instr;

    // an open request stays up until its hit, new ones start only when there is room
    assign imemREN   = pending || (!freeze && !buf_valid && !stopped);
    assign imemaddr  = pc;
    assign got       = imemREN && ihit;
    assign take      = got && !discard && !misprediction;
    assign open_next = imemREN && !ihit;
    assign f_instr   = instr_t'(imemload);

    // buffered word first, otherwise the word arriving this cycle
    always_comb begin
        if (buf_valid) begin
            fetch_out.valid = 1'b1;
            fetch_out.instr = buf_instr;
            fetch_out.pc    = buf_pc;
        end else begin
            fetch_out.valid = take;
            fetch_out.instr = imemload;
            fetch_out.pc    = pc;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc        <= word_t'(`DP_RESET_PC);
            pending   <= 1'b0;
            discard   <= 1'b0;
            stopped   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            pending <= open_next;
            if (misprediction) begin
                // redirect now, or after the open request returns
                buf_valid <= 1'b0;
                stopped   <= 1'b0;
                discard   <= open_next;
                if (!open_next) pc <= correct_pc;
            end else if (got && discard) begin
                discard <= 1'b0;
                pc      <= redirect_pc;
            end else if (take) begin
                pc        <= pc + word_t'(4);
                buf_valid <= freeze;
                // nothing past a halt is fetched
                if (f_instr.op == OP_HALT) stopped <= 1'b1;
            end else if (!freeze) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (misprediction && open_next) redirect_pc <= correct_pc;
        if (take && freeze) begin
            buf_instr <= imemload;
            buf_pc    <= pc;
        end
    end

endmodule

// ==== hw/scoreboard.sv ====
// scoreboard: decode, register file, busy bits, hazard stall and single issue
`timescale 1ns/1ps
`include "datapath_config.svh"

module scoreboard (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::fetch_t   fetch_in,
    input  logic                   ex_busy,
    input  logic                   branch_miss,
    input  logic                   wb_en,
    input  datapath_pkg::reg_sel_t wb_sel,
    input  datapath_pkg::word_t    wb_wdat,
    output logic                   freeze,
    output datapath_pkg::issue_t   issue_out
);
    import datapath_pkg::*;

    instr_t               ins;
    word_t                regs [`DP_NREGS];
    logic [`DP_NREGS-1:0] busy;
    logic [`DP_NREGS-1:0] busy_next;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 writes_rd;
    logic                 hazard;
    logic                 can_issue;
    word_t                rdat1;
    word_t                rdat2;

    assign ins = instr_t'(fetch_in.instr);

    // register fields each opcode really uses
    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (ins.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_ADDI, OP_LW: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_SW, OP_BEQ, OP_BNE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_JAL: begin
                writes_rd = 1'b1;
            end
            default: ;
        endcase
        // r0 is never tracked
        if (ins.rd == '0) writes_rd = 1'b0;
    end

    // rd is checked too, an older write must not clear a newer busy bit
    assign hazard = (uses_rs1 && busy[ins.rs1]) ||
                    (uses_rs2 && busy[ins.rs2]) ||
                    (writes_rd && busy[ins.rd]);

    assign can_issue = fetch_in.valid && !hazard && !ex_busy && !branch_miss;
    assign freeze    = fetch_in.valid && !can_issue;

    assign rdat1 = (ins.rs1 == '0) ? '0 : regs[ins.rs1];
    assign rdat2 = (ins.rs2 == '0) ? '0 : regs[ins.rs2];

    always_comb begin
        issue_out.valid = can_issue;
        issue_out.op    = ins.op;
        issue_out.rd    = ins.rd;
        issue_out.rdat1 = rdat1;
        issue_out.rdat2 = rdat2;
        issue_out.imm   = ins.imm;
        issue_out.pc    = fetch_in.pc;
    end

    // clear from writeback first, a new issue to the same register wins
    always_comb begin
        busy_next = busy;
        if (wb_en) busy_next[wb_sel] = 1'b0;
        if (can_issue && writes_rd) busy_next[ins.rd] = 1'b1;
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // writeback already drops r0 writes
    always_ff @(posedge CLK) begin
        if (wb_en) regs[wb_sel] <= wb_wdat;
    end

endmodule

// ==== hw/execute.sv ====
// execute: operation register, ALU, branch resolution, load/store sequencing and halt
`timescale 1ns/1ps

module execute (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::issue_t   issue_in,
    input  logic                   dhit,
    input  datapath_pkg::word_t    dmemload,
    output logic                   dmemREN,
    output logic                   dmemWEN,
    output datapath_pkg::word_t    dmemaddr,
    output datapath_pkg::word_t    dmemstore,
    output logic                   ex_busy,
    output logic                   misprediction,
    output logic                   halt,
    output datapath_pkg::word_t    correct_pc,
    output datapath_pkg::execute_t ex_out
);
    import datapath_pkg::*;

    issue_t op_q;
    word_t  imm_ext;
    word_t  alu_res;
    logic   is_load;
    logic   is_store;
    logic   mem_wait;
    logic   halt_now;
    logic   halted;
    logic   taken;

    assign imm_ext  = word_t'($signed(op_q.imm));
    assign is_load  = op_q.valid && (op_q.op == OP_LW);
    assign is_store = op_q.valid && (op_q.op == OP_SW);
    assign mem_wait = (is_load || is_store) && !dhit;
    assign halt_now = op_q.valid && (op_q.op == OP_HALT);

    assign halt    = halted || halt_now;
    assign ex_busy = halt || mem_wait;

    // memory request held steady by op_q until dhit
    assign dmemREN   = is_load;
    assign dmemWEN   = is_store;
    assign dmemaddr  = op_q.rdat1 + imm_ext;
    assign dmemstore = op_q.rdat2;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            op_q <= '0;
        end else if (!ex_busy) begin
            op_q <= issue_in;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halted <= 1'b0;
        end else if (halt_now) begin
            halted <= 1'b1;
        end
    end

    // not-taken is predicted, so jal and taken branches always redirect
    always_comb begin
        case (op_q.op)
            OP_BEQ:  taken = (op_q.rdat1 == op_q.rdat2);
            OP_BNE:  taken = (op_q.rdat1 != op_q.rdat2);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign misprediction = op_q.valid && taken;
    assign correct_pc    = op_q.pc + (imm_ext << 2);

    always_comb begin
        case (op_q.op)
            OP_ADD:  alu_res = op_q.rdat1 + op_q.rdat2;
            OP_SUB:  alu_res = op_q.rdat1 - op_q.rdat2;
            OP_AND:  alu_res = op_q.rdat1 & op_q.rdat2;
            OP_OR:   alu_res = op_q.rdat1 | op_q.rdat2;
            OP_XOR:  alu_res = op_q.rdat1 ^ op_q.rdat2;
            OP_ADDI: alu_res = op_q.rdat1 + imm_ext;
            OP_JAL:  alu_res = op_q.pc + word_t'(4);
            OP_LW:   alu_res = dmemload;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        ex_out.done    = op_q.valid && !halted && !mem_wait;
        ex_out.reg_en  = op_q.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                         OP_ADDI, OP_LW, OP_JAL};
        ex_out.reg_sel = op_q.rd;
        ex_out.wdat    = alu_res;
    end

endmodule

// ==== hw/writeback.sv ====
// writeback: picks the retiring result and registers the single register write
`timescale 1ns/1ps

module writeback (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::execute_t wb_in,
    output logic                   wb_en,
    output datapath_pkg::reg_sel_t wb_sel,
    output datapath_pkg::word_t    wb_wdat
);
    import datapath_pkg::*;

    reg_sel_t sel_q;
    word_t    wdat_q;
    logic     write_ok;

    // squashed or non-writing results and r0 targets produce no write
    assign write_ok = wb_in.done && wb_in.reg_en && (wb_in.reg_sel != '0);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= write_ok;
        end
    end

    always_ff @(posedge CLK) begin
        if (write_ok) begin
            sel_q  <= wb_in.reg_sel;
            wdat_q <= wb_in.wdat;
        end
    end

    assign wb_sel  = sel_q;
    assign wb_wdat = wdat_q;

endmodule

// ==== hw/sc_datapath.sv ====
// sc_datapath: top level joining fetch, scoreboard, execute, writeback and the latches
`timescale 1ns/1ps

module sc_datapath (
    input  logic                CLK,
    input  logic                nrst,
    // instruction memory
    output logic                imemREN,
    output datapath_pkg::word_t imemaddr,
    input  logic                ihit,
    input  datapath_pkg::word_t imemload,
    // data memory
    output logic                dmemREN,
    output logic                dmemWEN,
    output datapath_pkg::word_t dmemaddr,
    output datapath_pkg::word_t dmemstore,
    input  logic                dhit,
    input  datapath_pkg::word_t dmemload,
    output logic                halt
);
    import datapath_pkg::*;

    fetch_t   fetch_d;
    fetch_t   fetch_q;
    issue_t   issue;
    execute_t ex_d;
    execute_t ex_q;
    logic     freeze;
    logic     ex_busy;
    logic     misprediction;
    word_t    correct_pc;
    logic     wb_en;
    reg_sel_t wb_sel;
    word_t    wb_wdat;

    fetch_stage u_fetch (
        .CLK(CLK), .nrst(nrst),
        .ihit(ihit), .imemload(imemload),
        .freeze(freeze), .misprediction(misprediction), .correct_pc(correct_pc),
        .imemREN(imemREN), .imemaddr(imemaddr),
        .fetch_out(fetch_d)
    );

    // a miss empties the fetch latch, a stall holds it
    pipe_latch #(.payload_t(fetch_t)) u_fetch_latch (
        .CLK(CLK), .nrst(nrst),
        .hold(freeze), .flush(misprediction),
        .d(fetch_d), .q(fetch_q)
    );

    scoreboard u_scoreboard (
        .CLK(CLK), .nrst(nrst),
        .fetch_in(fetch_q),
        .ex_busy(ex_busy), .branch_miss(misprediction),
        .wb_en(wb_en), .wb_sel(wb_sel), .wb_wdat(wb_wdat),
        .freeze(freeze),
        .issue_out(issue)
    );

    execute u_execute (
        .CLK(CLK), .nrst(nrst),
        .issue_in(issue),
        .dhit(dhit), .dmemload(dmemload),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore),
        .ex_busy(ex_busy), .misprediction(misprediction), .halt(halt),
        .correct_pc(correct_pc),
        .ex_out(ex_d)
    );

    // writeback never stalls and sees no wrong-path results
    pipe_latch #(.payload_t(execute_t)) u_ex_latch (
        .CLK(CLK), .nrst(nrst),
        .hold(1'b0), .flush(1'b0),
        .d(ex_d), .q(ex_q)
    );

    writeback u_writeback (
        .CLK(CLK), .nrst(nrst),
        .wb_in(ex_q),
        .wb_en(wb_en), .wb_sel(wb_sel), .wb_wdat(wb_wdat)
    );

endmodule

// ==== sim/sc_datapath_asserts.sv ====
// sc_datapath_asserts: memory handshake and halt properties, bound into sc_datapath
`timescale 1ns/1ps

module sc_datapath_asserts (
    input logic                CLK,
    input logic                nrst,
    input logic                imemREN,
    input logic                ihit,
    input datapath_pkg::word_t imemaddr,
    input logic                dmemREN,
    input logic                dmemWEN,
    input logic                dhit,
    input datapath_pkg::word_t dmemaddr,
    input datapath_pkg::word_t dmemstore,
    input logic                halt
);

    // a request stays up with a steady address until its hit
    imem_hold: assert property (@(posedge CLK) disable iff (!nrst)
        imemREN && !ihit |=> imemREN && $stable(imemaddr))
        else $error("instruction request dropped or moved before ihit");

    dmem_read_hold: assert property (@(posedge CLK) disable iff (!nrst)
        dmemREN && !dhit |=> dmemREN && $stable(dmemaddr))
        else $error("data read dropped or moved before dhit");

    dmem_write_hold: assert property (@(posedge CLK) disable iff (!nrst)
        dmemWEN && !dhit |=> dmemWEN && $stable(dmemaddr) && $stable(dmemstore))
        else $error("data write dropped or changed before dhit");

    // halt is sticky until reset
    halt_sticky: assert property (@(posedge CLK) disable iff (!nrst)
        halt |=> halt)
        else $error("halt fell without reset");

    halt_quiet: assert property (@(posedge CLK) disable iff (!nrst)
        halt |=> !$rose(imemREN) && !$rose(dmemREN) && !$rose(dmemWEN))
        else $error("memory enable rose after halt");

endmodule

bind sc_datapath sc_datapath_asserts u_asserts (.*);

// ==== sim/sc_datapath_tb.sv ====
// sc_datapath_tb: clock, reset, random programs, memory responders, ISA model, compare tasks
`timescale 1ns/1ps
`include "datapath_config.svh"

module sc_datapath_tb;
    import datapath_pkg::*;

    localparam int RUN_LIMIT = 20000;
    localparam int RUNS      = 3;

    logic  CLK;
    logic  nrst     = 1'b0;
    logic  ihit     = 1'b0;
    word_t imemload = '0;
    logic  dhit     = 1'b0;
    word_t dmemload = '0;
    logic  imemREN;
    logic  dmemREN;
    logic  dmemWEN;
    logic  halt;
    word_t imemaddr;
    word_t dmemaddr;
    word_t dmemstore;

    word_t prog  [128];
    word_t saved [128];
    int    prog_len;
    int    saved_len;
    int    dly_min;
    int    dly_max;
    int    err_count;
    int    icount;
    int    dcount;
    word_t dmem [word_t];
    word_t got_addr [$];
    word_t got_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    sc_datapath DUT (
        .CLK(CLK), .nrst(nrst),
        .imemREN(imemREN), .imemaddr(imemaddr), .ihit(ihit), .imemload(imemload),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
        .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload),
        .halt(halt)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // unwritten data words, spread over the whole address
    function automatic word_t dmem_fill(input word_t a);
        return (a * 32'h9E37_79B9) ^ 32'hC3A5_5A3C;
    endfunction

    // outside the program the memory holds halt words
    function automatic word_t imem_word(input word_t a);
        if (a[1:0] == 2'b00 && (a >> 2) < word_t'(prog_len)) begin
            return prog[a[8:2]];
        end
        return {4'hB, 12'h000, a[15:0] ^ a[31:16]};
    endfunction

    function automatic word_t enc(input opcode_t op, input int rd, input int rs1,
                                 input int rs2, input int imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = reg_sel_t'(rd);
        ins.rs1 = reg_sel_t'(rs1);
        ins.rs2 = reg_sel_t'(rs2);
        ins.imm = 16'(imm);
        return word_t'(ins);
    endfunction

    function automatic int pick_delay();
        return dly_min + int'($urandom % (dly_max - dly_min + 1));
    endfunction

    // both memories: count the delay, raise the hit for one cycle
    always @(posedge CLK) begin
        if (!nrst) begin
            ihit <= 1'b0;
            dhit <= 1'b0;
            icount = -1;
            dcount = -1;
            dmem.delete();
            got_addr.delete();
            got_data.delete();
        end else begin
            if (ihit) begin
                ihit <= 1'b0;
            end else if (imemREN) begin
                if (icount < 0) icount = pick_delay();
                if (icount == 0) begin
                    ihit     <= 1'b1;
                    imemload <= imem_word(imemaddr);
                end
                icount = icount - 1;
            end
            if (dhit) begin
                dhit <= 1'b0;
            end else if (dmemREN || dmemWEN) begin
                if (dcount < 0) dcount = pick_delay();
                if (dcount == 0) begin
                    dhit <= 1'b1;
                    if (dmemWEN) begin
                        dmem[dmemaddr] = dmemstore;
                        got_addr.push_back(dmemaddr);
                        got_data.push_back(dmemstore);
                    end else begin
                        dmemload <= dmem.exists(dmemaddr) ? dmem[dmemaddr] : dmem_fill(dmemaddr);
                    end
                end
                dcount = dcount - 1;
            end
        end
    end

    task automatic note_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        err_count++;
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_halt(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: halt expected %b, got %b", $time, expected, actual);
            err_count++;
        end
    endtask

    // kind 1 alu only, 2 adds loads and stores, 3 adds branches and jal, 5 mixes all
    task automatic gen_program(input int kind);
        int      body_end;
        int      sel;
        int      nreg;
        int      r1;
        int      r2;
        opcode_t op;
        prog_len = 0;
        nreg = (kind == 1) ? 6 : 16;
        for (int k = 1; k < `DP_NREGS; k++) begin
            prog[prog_len] = enc(OP_ADDI, k, 0, 0, int'($urandom));
            prog_len++;
        end
        body_end = prog_len + 20 + int'($urandom % 21);
        while (prog_len < body_end) begin
            sel = int'($urandom % 10);
            r1  = int'($urandom % nreg);
            r2  = int'($urandom % nreg);
            if ((kind == 2 || kind == 5) && sel < 3) begin
                op = (sel == 0) ? OP_SW : OP_LW;
                if ($urandom % 2 == 0) r1 = 0;
                prog[prog_len] = enc(op, int'($urandom % nreg), r1, r2,
                                     256 + 4 * int'($urandom % 8));
            end else if (kind == 3 && sel == 0) begin
                prog[prog_len] = enc(OP_SW, 0, 0, r2, 256 + 4 * int'($urandom % 8));
            end else if ((kind == 3 || kind == 5) && sel >= 7) begin
                op = (sel == 7) ? OP_BEQ : (sel == 8) ? OP_BNE : OP_JAL;
                if ($urandom % 3 == 0) r2 = r1;
                // forward only, at most to the start of the register dump
                prog[prog_len] = enc(op, int'($urandom % nreg), r1, r2,
                                     1 + int'($urandom % (body_end - prog_len)));
            end else begin
                op = opcode_t'(4'($urandom % 6));
                prog[prog_len] = enc(op, int'($urandom % nreg), r1, r2, int'($urandom));
            end
            prog_len++;
        end
        for (int k = 1; k < `DP_NREGS; k++) begin
            prog[prog_len] = enc(OP_SW, 0, 0, k, 1024 + 4 * k);
            prog_len++;
        end
        prog[prog_len] = enc(OP_HALT, 0, 0, 0, 0);
        prog_len++;
    endtask

    // instruction set model, builds the expected store list
    task automatic run_model();
        word_t  r [`DP_NREGS];
        word_t  mem [word_t];
        instr_t ins;
        word_t  imm;
        word_t  addr;
        word_t  res;
        int     pc;
        int     steps;
        logic   wr;
        logic   stop;
        exp_addr.delete();
        exp_data.delete();
        foreach (r[k]) r[k] = '0;
        pc    = 0;
        steps = 0;
        stop  = 1'b0;
        while (!stop && steps < 4000) begin
            ins  = instr_t'(imem_word(word_t'(pc) << 2));
            imm  = {{16{ins.imm[15]}}, ins.imm};
            addr = r[ins.rs1] + imm;
            res  = '0;
            wr   = 1'b0;
            steps++;
            pc++;
            case (ins.op)
                OP_ADD:  begin res = r[ins.rs1] + r[ins.rs2]; wr = 1'b1; end
                OP_SUB:  begin res = r[ins.rs1] - r[ins.rs2]; wr = 1'b1; end
                OP_AND:  begin res = r[ins.rs1] & r[ins.rs2]; wr = 1'b1; end
                OP_OR:   begin res = r[ins.rs1] | r[ins.rs2]; wr = 1'b1; end
                OP_XOR:  begin res = r[ins.rs1] ^ r[ins.rs2]; wr = 1'b1; end
                OP_ADDI: begin res = addr; wr = 1'b1; end
                OP_LW: begin
                    res = mem.exists(addr) ? mem[addr] : dmem_fill(addr);
                    wr  = 1'b1;
                end
                OP_SW: begin
                    mem[addr] = r[ins.rs2];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ins.rs2]);
                end
                OP_BEQ: if (r[ins.rs1] == r[ins.rs2]) pc = pc - 1 + int'($signed(ins.imm));
                OP_BNE: if (r[ins.rs1] != r[ins.rs2]) pc = pc - 1 + int'($signed(ins.imm));
                OP_JAL: begin
                    res = word_t'(pc) << 2;
                    wr  = 1'b1;
                    pc  = pc - 1 + int'($signed(ins.imm));
                end
                default: stop = 1'b1;
            endcase
            if (wr && ins.rd != '0) r[ins.rd] = res;
        end
        if (!stop) note_failure("reference model did not reach a halt");
    endtask

    task automatic check_stores();
        if (got_addr.size() != exp_addr.size()) begin
            note_failure($sformatf("store count differs: expected %0d, got %0d",
                                   exp_addr.size(), got_addr.size()));
        end
        for (int k = 0; k < exp_addr.size() && k < got_addr.size(); k++) begin
            compare_word($sformatf("store %0d dmemaddr", k), exp_addr[k], got_addr[k]);
            compare_word($sformatf("store %0d dmemstore", k), exp_data[k], got_data[k]);
        end
    endtask

    task automatic run_program(input int d_min, input int d_max, output logic timed_out);
        int   cycles;
        logic en_prev;
        logic en_now;
        timed_out = 1'b0;
        dly_min   = d_min;
        dly_max   = d_max;
        run_model();
        @(posedge CLK);
        nrst <= 1'b0;
        repeat (16) @(posedge CLK);
        nrst <= 1'b1;
        cycles = 0;
        while (halt !== 1'b1 && cycles < RUN_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (halt !== 1'b1) begin
            note_failure($sformatf("halt not seen within %0d cycles", RUN_LIMIT));
            timed_out = 1'b1;
        end else begin
            check_stores();
            // after halt the datapath stays quiet
            en_prev = imemREN | dmemREN | dmemWEN;
            for (int c = 0; c < 50; c++) begin
                @(negedge CLK);
                compare_halt(1'b1, halt);
                en_now = imemREN | dmemREN | dmemWEN;
                if (en_now && !en_prev) note_failure("memory enable rose after halt");
                en_prev = en_now;
            end
        end
    endtask

    initial begin
        string names [5];
        int    n_pass;
        int    n_fail;
        int    start_err;
        logic  hung;
        void'($urandom(71010));
        names     = '{"alu hazards", "loads and stores", "branches and jal",
                      "slow memories", "halt quiet"};
        err_count = 0;
        n_pass    = 0;
        n_fail    = 0;
        prog_len  = 0;
        dly_min   = 0;
        dly_max   = 4;
        hung      = 1'b0;
        for (int t = 1; t <= 5 && !hung; t++) begin
            start_err = err_count;
            for (int p = 0; p < RUNS && !hung; p++) begin
                if (t == 4) begin
                    // same program as the last one of test 2, slower memories
                    prog     = saved;
                    prog_len = saved_len;
                    run_program(4, 12, hung);
                end else begin
                    gen_program(t);
                    run_program(0, 4, hung);
                end
            end
            if (t == 2) begin
                saved     = prog;
                saved_len = prog_len;
            end
            if (err_count == start_err) begin
                n_pass++;
                $display("test %0d %s: ok", t, names[t-1]);
            end else begin
                n_fail++;
                $display("test %0d %s: %0d errors", t, names[t-1], err_count - start_err);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/datapath_pkg.sv
hw/pipe_latch.sv
hw/fetch_stage.sv
hw/scoreboard.sv
hw/execute.sv
hw/writeback.sv
hw/sc_datapath.sv
sim/sc_datapath_asserts.sv
sim/sc_datapath_tb.sv

// ==== Makefile ====
TOP := sc_datapath_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@! grep -q "Test failed" sim.log
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
